//--- flist.f
+incdir+include
src/hist_cmd_pkg.sv
src/hist_pipe_pkg.sv
src/count_ram_readfirst.sv
src/hist_issue_stage.sv
src/hist_update_stage.sv
src/hist_top.sv
verification/hist_tb.sv

//--- include/hist_macros.svh
// histogram width parameters
// bin index, count and weight widths shared by the whole design

`ifndef HIST_MACROS_SVH
`define HIST_MACROS_SVH

// number of bins is 2 ** HIST_BIN_BITS
`define HIST_BIN_BITS 4

// counts saturate at all ones
`define HIST_COUNT_BITS 8

// width of the weight carried by an add command
`define HIST_WEIGHT_BITS 4

`endif

//--- run_sim.sh
#!/bin/sh
# build the histogram testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module hist_tb -o hist_sim

# the log decides the outcome, so a failing run must not stop the script here
./obj_dir/hist_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
	echo "run_sim: PASS"
	exit 0
fi

echo "run_sim: FAIL, see sim.log"
exit 1

//--- src/count_ram_readfirst.sv
// count memory
// simple dual-port RAM, read before write, one cycle read latency
// a read colliding with a write to the same bin sees the old count

`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module count_ram_readfirst
(
	input wire wclock,
	input wire logic wenable,
	input wire logic [`HIST_BIN_BITS-1:0] waddr,
	input wire logic [`HIST_COUNT_BITS-1:0] wdata,
	input wire logic renable,
	input wire logic [`HIST_BIN_BITS-1:0] raddr,
	output logic [`HIST_COUNT_BITS-1:0] rdata
);

	localparam int DEPTH = 1 << `HIST_BIN_BITS;

	logic [`HIST_COUNT_BITS-1:0] memory [0:DEPTH-1];

	always_ff @(posedge wclock)
	begin
		if (wenable)
			memory[waddr] <= wdata;
	end

	// nonblocking read of the old content gives read-first behavior
	always_ff @(posedge wclock)
	begin
		if (renable)
			rdata <= memory[raddr];
	end

endmodule

`default_nettype wire

//--- src/hist_cmd_pkg.sv
// histogram command interface types
// opcode encoding, command and response records seen at the top level

`default_nettype none

`include "hist_macros.svh"

package hist_cmd_pkg;

	// add saturates, read-clear returns the count then zeroes the bin
	typedef enum logic [1:0]
	{
		OP_NOP        = 2'd0,
		OP_ADD        = 2'd1,
		OP_READ       = 2'd2,
		OP_READ_CLEAR = 2'd3
	} hist_op_e;

	typedef struct packed
	{
		hist_op_e                      op;
		logic [`HIST_BIN_BITS-1:0]    bin;
		logic [`HIST_WEIGHT_BITS-1:0] weight;
	} hist_cmd_t;

	// returned for read and read-clear only
	typedef struct packed
	{
		logic [`HIST_BIN_BITS-1:0]   bin;
		logic [`HIST_COUNT_BITS-1:0] count;
	} hist_rsp_t;

endpackage

`default_nettype wire

//--- src/hist_issue_stage.sv
// histogram issue stage
// clears every bin after reset, then turns commands into RAM reads
// and pipeline items; owns the RAM write port mux

`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_issue_stage
(
	input wire wclock,
	input wire rst,
	input wire logic cmd_valid,
	input wire hist_cmd_pkg::hist_cmd_t cmd,
	input wire hist_pipe_pkg::wb_item_t wb,
	output logic busy,
	output logic renable,
	output logic [`HIST_BIN_BITS-1:0] raddr,
	output logic wenable,
	output logic [`HIST_BIN_BITS-1:0] waddr,
	output logic [`HIST_COUNT_BITS-1:0] wdata,
	output hist_pipe_pkg::pipe_item_t item
);

	hist_pipe_pkg::sweep_state_e sweep_state;
	logic [`HIST_BIN_BITS-1:0] sweep_bin;
	logic accept;

	assign busy = (sweep_state == hist_pipe_pkg::SWEEP_CLEAR);

	// one bin zeroed per cycle, done after the last one
	always_ff @(posedge wclock)
	begin
		if (rst)
		begin
			sweep_state <= hist_pipe_pkg::SWEEP_CLEAR;
			sweep_bin <= '0;
		end
		else if (sweep_state == hist_pipe_pkg::SWEEP_CLEAR)
		begin
			sweep_bin <= sweep_bin + 1'b1;
			if (sweep_bin == {`HIST_BIN_BITS{1'b1}})
				sweep_state <= hist_pipe_pkg::SWEEP_DONE;
		end
	end

	// nop and anything during the sweep are dropped
	assign accept = cmd_valid && !busy && (cmd.op != hist_cmd_pkg::OP_NOP);

	assign renable = accept;
	assign raddr = cmd.bin;

	always_ff @(posedge wclock)
	begin
		if (rst)
			item.valid <= 1'b0;
		else
			item.valid <= accept;
		if (accept)
		begin
			item.op <= cmd.op;
			item.bin <= cmd.bin;
			item.weight <= cmd.weight;
		end
	end

	// sweep writes take the port while busy, write-back otherwise
	assign wenable = busy ? 1'b1 : wb.valid;
	assign waddr = busy ? sweep_bin : wb.bin;
	assign wdata = busy ? '0 : wb.count;

endmodule

`default_nettype wire

//--- src/hist_pipe_pkg.sv
// histogram pipeline internal types
// stage-to-stage items, write-back records and clear sweep states

`default_nettype none

`include "hist_macros.svh"

package hist_pipe_pkg;

	// clear sweep runs once after reset
	typedef enum logic
	{
		SWEEP_CLEAR = 1'b0,
		SWEEP_DONE  = 1'b1
	} sweep_state_e;

	// accepted command as held between issue and update
	typedef struct packed
	{
		logic                          valid;
		hist_cmd_pkg::hist_op_e        op;
		logic [`HIST_BIN_BITS-1:0]    bin;
		logic [`HIST_WEIGHT_BITS-1:0] weight;
	} pipe_item_t;

	// one pending RAM write, also kept as forwarding history
	typedef struct packed
	{
		logic                        valid;
		logic [`HIST_BIN_BITS-1:0]   bin;
		logic [`HIST_COUNT_BITS-1:0] count;
	} wb_item_t;

endpackage

`default_nettype wire

//--- src/hist_top.sv
// weighted histogram accumulator
// issue stage, read-first count RAM and update stage in one pipeline

`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_top
(
	input wire wclock,
	input wire rst,
	input wire logic cmd_valid,
	input wire hist_cmd_pkg::hist_cmd_t cmd,
	output logic busy,
	output logic rsp_valid,
	output hist_cmd_pkg::hist_rsp_t rsp
);

	logic renable;
	logic [`HIST_BIN_BITS-1:0] raddr;
	logic [`HIST_COUNT_BITS-1:0] rdata;
	logic wenable;
	logic [`HIST_BIN_BITS-1:0] waddr;
	logic [`HIST_COUNT_BITS-1:0] wdata;
	hist_pipe_pkg::pipe_item_t item;
	hist_pipe_pkg::wb_item_t wb;

	hist_issue_stage i_issue
	(
		.wclock    (wclock),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.wb        (wb),
		.busy      (busy),
		.renable   (renable),
		.raddr     (raddr),
		.wenable   (wenable),
		.waddr     (waddr),
		.wdata     (wdata),
		.item      (item)
	);

	count_ram_readfirst i_ram
	(
		.wclock  (wclock),
		.wenable (wenable),
		.waddr   (waddr),
		.wdata   (wdata),
		.renable (renable),
		.raddr   (raddr),
		.rdata   (rdata)
	);

	hist_update_stage i_update
	(
		.wclock    (wclock),
		.rst       (rst),
		.item      (item),
		.rdata     (rdata),
		.wb        (wb),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

//--- src/hist_update_stage.sv
// histogram update stage
// picks the current count from RAM or forwarded write-backs, applies
// the opcode and registers the write-back record and the response

`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_update_stage
(
	input wire wclock,
	input wire rst,
	input wire hist_pipe_pkg::pipe_item_t item,
	input wire logic [`HIST_COUNT_BITS-1:0] rdata,
	output hist_pipe_pkg::wb_item_t wb,
	output logic rsp_valid,
	output hist_cmd_pkg::hist_rsp_t rsp
);

	// older write-back, already in RAM but missed by the read-first read
	hist_pipe_pkg::wb_item_t wb_prev;
	hist_pipe_pkg::wb_item_t wb_next;
	logic [`HIST_COUNT_BITS-1:0] cur_count;
	logic [`HIST_COUNT_BITS:0] sum;
	logic [`HIST_COUNT_BITS-1:0] sat_count;
	logic rsp_next;

	// youngest matching record wins
	always_comb
	begin
		if (wb.valid && (wb.bin == item.bin))
			cur_count = wb.count;
		else if (wb_prev.valid && (wb_prev.bin == item.bin))
			cur_count = wb_prev.count;
		else
			cur_count = rdata;
	end

	assign sum = {1'b0, cur_count} + (`HIST_COUNT_BITS+1)'(item.weight);
	assign sat_count = sum[`HIST_COUNT_BITS] ? {`HIST_COUNT_BITS{1'b1}}
		: sum[`HIST_COUNT_BITS-1:0];

	always_comb
	begin
		wb_next.valid = 1'b0;
		wb_next.bin = item.bin;
		wb_next.count = '0;
		rsp_next = 1'b0;
		case (item.op)
			hist_cmd_pkg::OP_ADD:
			begin
				wb_next.valid = item.valid;
				wb_next.count = sat_count;
			end
			hist_cmd_pkg::OP_READ:
				rsp_next = item.valid;
			hist_cmd_pkg::OP_READ_CLEAR:
			begin
				wb_next.valid = item.valid;
				rsp_next = item.valid;
			end
			default:
				wb_next.valid = 1'b0;
		endcase
	end

	always_ff @(posedge wclock)
	begin
		if (rst)
		begin
			wb.valid <= 1'b0;
			wb_prev.valid <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			wb.valid <= wb_next.valid;
			wb_prev.valid <= wb.valid;
			rsp_valid <= rsp_next;
		end
		wb.bin <= wb_next.bin;
		wb.count <= wb_next.count;
		wb_prev.bin <= wb.bin;
		wb_prev.count <= wb.count;
		rsp.bin <= item.bin;
		rsp.count <= cur_count;
	end

endmodule

`default_nettype wire

//--- verification/hist_stim.txt
# columns: opcode bin weight gap expected (decimal)
# opcode 1 add, 2 read, 3 read-clear; gap is idle cycles after the command
# expected is the response count and is ignored for add lines
# the first command is driven while the clear sweep runs and is dropped
1 5 9 0 0
# untouched bins read zero after the sweep
2 0 0 1 0
2 15 0 1 0
2 5 0 2 0
# spaced adds to several bins
1 1 3 3 0
1 2 7 3 0
1 1 4 3 0
1 3 15 3 0
1 2 2 3 0
2 1 0 2 7
2 2 0 2 9
2 3 0 2 15
# back-to-back adds, no gap, read right behind them
1 4 5 0 0
1 4 6 0 0
1 4 7 0 0
2 4 0 2 18
# adds one idle cycle apart
1 6 2 1 0
1 6 3 1 0
1 6 4 1 0
2 6 0 1 9
# mixed spacing on one bin
1 7 1 0 0
1 7 2 1 0
1 7 3 0 0
2 7 0 1 6
# read-clear, then reads with and without a gap
3 1 0 2 7
2 1 0 2 0
3 2 0 0 9
2 2 0 2 0
3 3 0 0 15
1 3 4 0 0
2 3 0 2 4
3 4 0 0 18
3 4 0 2 0
# saturation at 255 on bin 8
1 8 15 0 0
1 8 15 0 0
1 8 15 0 0
1 8 15 0 0
1 8 15 0 0
1 8 15 0 0
1 8 15 0 0
1 8 15 0 0
1 8 15 0 0
2 8 0 1 135
1 8 15 0 0
1 8 15 1 0
1 8 15 0 0
1 8 15 1 0
1 8 15 0 0
1 8 15 0 0
1 8 15 1 0
1 8 15 0 0
1 8 15 0 0
2 8 0 2 255
3 8 0 0 255
2 8 0 2 0
2 5 0 2 0

//--- verification/hist_tb.sv
// histogram accumulator testbench
// replays the command lines of the stim file into the DUT and checks
// every response against the expected counts listed there

`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_tb;

	localparam int SWEEP_TIMEOUT = 64;
	localparam int DRAIN_TIMEOUT = 32;
	// cycles from driving a command to seeing its response on a falling edge
	localparam int RSP_LATENCY = 2;

	logic wclock;
	logic rst;
	logic cmd_valid;
	hist_cmd_pkg::hist_cmd_t cmd;
	logic busy;
	logic rsp_valid;
	hist_cmd_pkg::hist_rsp_t rsp;

	// responses still owed by the DUT in issue order
	hist_cmd_pkg::hist_rsp_t expect_q[$];
	hist_cmd_pkg::hist_rsp_t exp_rsp;
	// rising edge count at which each owed response must be visible
	int unsigned due_q[$];
	int unsigned exp_due;
	int unsigned cycle_count;

	hist_top i_dut
	(
		.wclock    (wclock),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	always
	begin
		#5 wclock = ~wclock;
	end

	always @(posedge wclock)
	begin
		cycle_count++;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else
			abort_run($sformatf("FAIL at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	// one-cycle strobe that starts and ends on a falling edge
	task automatic drive_cmd(input int op_code, input int bin, input int weight,
		input bit expect_rsp, input int expected);
		hist_cmd_pkg::hist_rsp_t exp_item;
		cmd.op = hist_cmd_pkg::hist_op_e'(op_code[1:0]);
		cmd.bin = bin[`HIST_BIN_BITS-1:0];
		cmd.weight = weight[`HIST_WEIGHT_BITS-1:0];
		cmd_valid = 1'b1;
		if (expect_rsp && (cmd.op == hist_cmd_pkg::OP_READ
			|| cmd.op == hist_cmd_pkg::OP_READ_CLEAR))
		begin
			exp_item.bin = bin[`HIST_BIN_BITS-1:0];
			exp_item.count = expected[`HIST_COUNT_BITS-1:0];
			expect_q.push_back(exp_item);
			due_q.push_back(cycle_count + RSP_LATENCY);
		end
		@(negedge wclock);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_for_idle();
		int cycles;
		cycles = 0;
		while (busy !== 1'b0)
		begin
			if (cycles == SWEEP_TIMEOUT)
				abort_run("busy never fell after the reset clear sweep");
			@(negedge wclock);
			cycles++;
		end
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (expect_q.size() != 0)
		begin
			if (cycles == DRAIN_TIMEOUT)
				abort_run("expected responses never arrived from the DUT");
			@(negedge wclock);
			cycles++;
		end
	endtask

	// responses are sampled half a cycle after they are registered
	always @(negedge wclock)
	begin
		if (rsp_valid === 1'b1)
		begin
			assert (expect_q.size() > 0)
			else
				abort_run("rsp_valid was high with no read or read-clear outstanding");
			exp_rsp = expect_q.pop_front();
			exp_due = due_q.pop_front();
			check_value("rsp_valid cycle", int'(exp_due), int'(cycle_count));
			check_value("rsp.bin", int'(exp_rsp.bin), int'(rsp.bin));
			check_value("rsp.count", int'(exp_rsp.count), int'(rsp.count));
		end
	end

	initial
	begin
		int fd;
		string line;
		int fields;
		int op_code;
		int bin;
		int weight;
		int gap;
		int expected;
		bit first_cmd;

		wclock = 1'b0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		cycle_count = 0;
		first_cmd = 1'b1;

		fd = $fopen("verification/hist_stim.txt", "r");
		if (fd == 0)
			abort_run("could not open verification/hist_stim.txt");

		repeat (3) @(posedge wclock);
		@(negedge wclock);
		rst = 1'b0;

		while ($fgets(line, fd) != 0)
		begin
			if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
				continue;
			fields = $sscanf(line, "%d %d %d %d %d", op_code, bin, weight, gap, expected);
			if (fields != 5)
				abort_run({"malformed stimulus line: ", line});
			if (first_cmd)
			begin
				// the first command lands in the last sweep cycle so that
				// a wrongly accepted add would still reach the RAM
				repeat ((1 << `HIST_BIN_BITS) - 1) @(negedge wclock);
				assert (busy === 1'b1)
				else
					abort_run("busy fell before the last cycle of the clear sweep");
				drive_cmd(op_code, bin, weight, 1'b0, expected);
				first_cmd = 1'b0;
				wait_for_idle();
			end
			else
			begin
				drive_cmd(op_code, bin, weight, 1'b1, expected);
				repeat (gap) @(negedge wclock);
			end
		end
		$fclose(fd);

		wait_for_drain();
		// room for a stray response to show up
		repeat (4) @(negedge wclock);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
